// ==== fpu_8097_top.sv ====
// FPU 8097 top level
`timescale 1ns/1ps

module fpu_8097_top import fpu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  csr_req_valid_i,
  output logic                  csr_req_ready_o,
  input  logic                  csr_req_write_i,
  input  logic [CSR_ADDR_W-1:0] csr_req_addr_i,
  input  logic [DATA_W-1:0]     csr_req_wdata_i,
  output logic                  csr_rsp_valid_o,
  input  logic                  csr_rsp_ready_i,
  output logic [DATA_W-1:0]     csr_rsp_rdata_o,
  output logic                  csr_rsp_fault_o,
  output logic                  mem_req_valid_o,
  input  logic                  mem_req_ready_i,
  output logic                  mem_req_write_o,
  output logic [ADDR_W-1:0]     mem_req_addr_o,
  output logic [DATA_W-1:0]     mem_req_wdata_o,
  input  logic                  mem_rsp_valid_i,
  output logic                  mem_rsp_ready_o,
  input  logic [DATA_W-1:0]     mem_rsp_rdata_i,
  input  logic                  mem_rsp_err_i
);

  logic              cmd_valid;
  logic [7:0]        cmd_op;
  logic [ADDR_W-1:0] mem_addr;
  logic              csr_fault_valid;
  fault_e            csr_fault_code;
  logic              busy;
  logic [15:0]       status_word;
  fault_e            fault_code;

  fpu_stack_if csr_stk ();
  fpu_stack_if exec_stk ();
  fpu_mem_if   mem_bus ();

  fpu_stack fpu_stack_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .csr_port_i  (csr_stk),
    .exec_port_i (exec_stk)
  );

  fpu_mem_port fpu_mem_port_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .seq_i           (mem_bus),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_write_o (mem_req_write_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_wdata_o (mem_req_wdata_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_ready_o (mem_rsp_ready_o),
    .mem_rsp_rdata_i (mem_rsp_rdata_i),
    .mem_rsp_err_i   (mem_rsp_err_i)
  );

  fpu_csr_window fpu_csr_window_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .csr_req_valid_i   (csr_req_valid_i),
    .csr_req_ready_o   (csr_req_ready_o),
    .csr_req_write_i   (csr_req_write_i),
    .csr_req_addr_i    (csr_req_addr_i),
    .csr_req_wdata_i   (csr_req_wdata_i),
    .csr_rsp_valid_o   (csr_rsp_valid_o),
    .csr_rsp_ready_i   (csr_rsp_ready_i),
    .csr_rsp_rdata_o   (csr_rsp_rdata_o),
    .csr_rsp_fault_o   (csr_rsp_fault_o),
    .stk_o             (csr_stk),
    .cmd_valid_o       (cmd_valid),
    .cmd_op_o          (cmd_op),
    .mem_addr_o        (mem_addr),
    .csr_fault_valid_o (csr_fault_valid),
    .csr_fault_code_o  (csr_fault_code),
    .busy_i            (busy),
    .status_word_i     (status_word),
    .fault_code_i      (fault_code)
  );

  fpu_exec fpu_exec_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .cmd_valid_i       (cmd_valid),
    .cmd_op_i          (cmd_op),
    .mem_addr_i        (mem_addr),
    .csr_fault_valid_i (csr_fault_valid),
    .csr_fault_code_i  (csr_fault_code),
    .stk_o             (exec_stk),
    .mem_o             (mem_bus),
    .busy_o            (busy),
    .status_word_o     (status_word),
    .fault_code_o      (fault_code)
  );

endmodule

// ==== fpu_csr_window.sv ====
// CSR window and stack staging
`timescale 1ns/1ps

module fpu_csr_window import fpu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  csr_req_valid_i,
  output logic                  csr_req_ready_o,
  input  logic                  csr_req_write_i,
  input  logic [CSR_ADDR_W-1:0] csr_req_addr_i,
  input  logic [DATA_W-1:0]     csr_req_wdata_i,
  output logic                  csr_rsp_valid_o,
  input  logic                  csr_rsp_ready_i,
  output logic [DATA_W-1:0]     csr_rsp_rdata_o,
  output logic                  csr_rsp_fault_o,
  fpu_stack_if.user             stk_o,
  output logic                  cmd_valid_o,
  output logic [7:0]            cmd_op_o,
  output logic [ADDR_W-1:0]     mem_addr_o,
  output logic                  csr_fault_valid_o,
  output fault_e                csr_fault_code_o,
  input  logic                  busy_i,
  input  logic [15:0]           status_word_i,
  input  fault_e                fault_code_i
);

  logic              rsp_valid_q;
  logic [DATA_W-1:0] rsp_rdata_q;
  logic              rsp_fault_q;
  logic [ADDR_W-1:0] mem_addr_q;
  logic [DATA_W-1:0] push_lo_q;
  logic              req_fire;
  logic              wr;
  csr_addr_e         req_addr;
  logic              empty;
  logic              full;
  logic [DATA_W-1:0] rd_data;
  logic              bad;
  logic              do_push;
  logic              do_pop;
  logic              launch;
  fault_e            flt_code;

  assign csr_req_ready_o = !rsp_valid_q;
  assign req_fire        = csr_req_valid_i & csr_req_ready_o;
  assign wr              = csr_req_write_i;
  assign req_addr        = csr_addr_e'(csr_req_addr_i);
  assign empty           = stk_o.depth == '0;
  assign full            = stk_o.depth == DEPTH_W'(STACK_DEPTH);

  // ------------------------------
  // Address decode
  // ------------------------------
  always_comb begin
    rd_data  = '0;
    bad      = 1'b0;
    do_push  = 1'b0;
    do_pop   = 1'b0;
    launch   = 1'b0;
    flt_code = FAULT_NONE;
    case (req_addr)
      CSR_ID: begin
        bad     = wr;
        rd_data = ID_VALUE;
      end
      CSR_STATUS: begin
        bad     = wr;
        rd_data = {8'd0, fault_code_i, 7'd0, stk_o.top, stk_o.depth,
                   fault_code_i != FAULT_NONE, busy_i};
      end
      CSR_STATUS_WORD: begin
        bad     = wr;
        rd_data = DATA_W'(status_word_i);
      end
      CSR_MEM_ADDR: rd_data = mem_addr_o;
      CSR_PUSH_LO:  bad = !wr;
      CSR_PUSH_HI: begin
        if (!wr)
          bad = 1'b1;
        else if (busy_i)
          flt_code = FAULT_BUSY;
        else if (full)
          flt_code = FAULT_STACK_OVERFLOW;
        else
          do_push = 1'b1;
      end
      CSR_POP_LO, CSR_POP_HI: begin
        if (wr)
          bad = 1'b1;
        else if (busy_i)
          flt_code = FAULT_BUSY;
        else if (empty)
          flt_code = FAULT_STACK_UNDERFLOW;
        else begin
          // LO only peeks, HI also pops
          do_pop  = req_addr == CSR_POP_HI;
          rd_data = do_pop ? stk_o.top_data[VAL_W-1:DATA_W] : stk_o.top_data[DATA_W-1:0];
        end
      end
      CSR_CMD: begin
        if (!wr)
          bad = 1'b1;
        else if (busy_i)
          flt_code = FAULT_BUSY;
        else
          launch = 1'b1;
      end
      default: bad = 1'b1;
    endcase
    bad = bad | (flt_code != FAULT_NONE);
  end

  assign stk_o.push        = req_fire & do_push;
  assign stk_o.push_data   = {csr_req_wdata_i, push_lo_q};
  assign stk_o.pop         = req_fire & do_pop;
  assign stk_o.wr_top      = 1'b0;
  assign stk_o.wr_data     = stk_o.push_data;
  assign cmd_valid_o       = req_fire & launch;
  assign cmd_op_o          = csr_req_wdata_i[7:0];
  assign csr_fault_valid_o = req_fire & (flt_code != FAULT_NONE);
  assign csr_fault_code_o  = flt_code;
  assign mem_addr_o        = mem_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
      mem_addr_q  <= '0;
    end else if (req_fire) begin
      rsp_valid_q <= 1'b1;
      if (wr && req_addr == CSR_MEM_ADDR)
        mem_addr_q <= csr_req_wdata_i;
    end else if (csr_rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      rsp_rdata_q <= (bad || wr) ? '0 : rd_data;
      rsp_fault_q <= bad;
      if (wr && req_addr == CSR_PUSH_LO)
        push_lo_q <= csr_req_wdata_i;
    end
  end

  assign csr_rsp_valid_o = rsp_valid_q;
  assign csr_rsp_rdata_o = rsp_rdata_q;
  assign csr_rsp_fault_o = rsp_fault_q;

endmodule

// ==== fpu_exec.sv ====
// Command sequencer and status word
`timescale 1ns/1ps

module fpu_exec import fpu_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              cmd_valid_i,
  input  logic [7:0]        cmd_op_i,
  input  logic [ADDR_W-1:0] mem_addr_i,
  input  logic              csr_fault_valid_i,
  input  fault_e            csr_fault_code_i,
  fpu_stack_if.user         stk_o,
  fpu_mem_if.seq            mem_o,
  output logic              busy_o,
  output logic [15:0]       status_word_o,
  output fault_e            fault_code_o
);

  exec_state_e      state_q;
  cmd_e             op_q;
  fault_e           fault_q;
  logic             busy_q;
  logic             ie_q;
  logic             sf_q;
  logic             c0_q;
  logic             c2_q;
  logic             c3_q;
  logic             legal;
  logic             dec_ok;
  logic             is_mem;
  logic             unordered;
  logic             equal;
  logic             less;

  function automatic logic is_nan(input logic [VAL_W-1:0] v);
    return (v[62:52] == 11'h7ff) && (v[51:0] != '0);
  endfunction

  // Unsigned compare of keys follows FP ordering
  function automatic logic [VAL_W-1:0] order_key(input logic [VAL_W-1:0] v);
    return v[VAL_W-1] ? ~v : {1'b1, v[VAL_W-2:0]};
  endfunction

  assign unordered = is_nan(stk_o.top_data) | is_nan(stk_o.next_data);
  assign equal     = (stk_o.top_data == stk_o.next_data) ||
                     (stk_o.top_data[VAL_W-2:0] == '0 && stk_o.next_data[VAL_W-2:0] == '0);
  assign less      = order_key(stk_o.top_data) < order_key(stk_o.next_data);

  // ------------------------------
  // Stack depth check per command
  // ------------------------------
  always_comb begin
    legal  = 1'b1;
    dec_ok = 1'b1;
    case (op_q)
      CMD_NOP:             dec_ok = 1'b1;
      CMD_FCOM, CMD_FCOMP: dec_ok = stk_o.depth >= DEPTH_W'(2);
      CMD_FLD_MEM64:       dec_ok = stk_o.depth != DEPTH_W'(STACK_DEPTH);
      CMD_FSTP_MEM64:      dec_ok = stk_o.depth != '0;
      default: begin
        legal  = 1'b0;
        dec_ok = 1'b0;
      end
    endcase
  end

  assign is_mem      = (op_q == CMD_FLD_MEM64) || (op_q == CMD_FSTP_MEM64);
  assign mem_o.start = (state_q == EXEC_DECODE) && is_mem && dec_ok;
  assign mem_o.write = op_q == CMD_FSTP_MEM64;
  assign mem_o.addr  = mem_addr_i;
  assign mem_o.wdata = stk_o.top_data;

  assign stk_o.push      = (state_q == EXEC_FINISH) && (op_q == CMD_FLD_MEM64);
  assign stk_o.push_data = mem_o.rdata;
  assign stk_o.pop       = ((state_q == EXEC_DECODE) && (op_q == CMD_FCOMP) && dec_ok) ||
                           ((state_q == EXEC_FINISH) && (op_q == CMD_FSTP_MEM64));
  assign stk_o.wr_top    = 1'b0;
  assign stk_o.wr_data   = mem_o.rdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= EXEC_IDLE;
      op_q    <= CMD_NOP;
      fault_q <= FAULT_NONE;
      busy_q  <= 1'b0;
      ie_q    <= 1'b0;
      sf_q    <= 1'b0;
      c0_q    <= 1'b0;
      c2_q    <= 1'b0;
      c3_q    <= 1'b0;
    end else begin
      if (csr_fault_valid_i) begin
        fault_q <= csr_fault_code_i;
        if (csr_fault_code_i != FAULT_BUSY)
          sf_q <= 1'b1;
      end
      case (state_q)
        EXEC_IDLE: begin
          if (cmd_valid_i) begin
            busy_q  <= 1'b1;
            op_q    <= cmd_e'(cmd_op_i);
            state_q <= EXEC_DECODE;
          end
        end
        EXEC_DECODE: begin
          if (!legal) begin
            fault_q <= FAULT_ILLEGAL_CMD;
          end else if (!dec_ok) begin
            sf_q <= 1'b1;
            if (op_q == CMD_FLD_MEM64)
              fault_q <= FAULT_STACK_OVERFLOW;
            else
              fault_q <= FAULT_STACK_UNDERFLOW;
          end else if (op_q == CMD_FCOM || op_q == CMD_FCOMP) begin
            c3_q <= unordered | equal;
            c2_q <= unordered;
            c0_q <= unordered | (!equal & less);
            ie_q <= ie_q | unordered;
          end
          if (mem_o.start) begin
            state_q <= EXEC_MEM_WAIT;
          end else begin
            busy_q  <= 1'b0;
            state_q <= EXEC_IDLE;
          end
        end
        EXEC_MEM_WAIT: begin
          if (mem_o.done && mem_o.err) begin
            fault_q <= FAULT_MEM;
            busy_q  <= 1'b0;
            state_q <= EXEC_IDLE;
          end else if (mem_o.done) begin
            state_q <= EXEC_FINISH;
          end
        end
        EXEC_FINISH: begin
          busy_q  <= 1'b0;
          state_q <= EXEC_IDLE;
        end
        default: state_q <= EXEC_IDLE;
      endcase
    end
  end

  always_comb begin
    status_word_o                           = '0;
    status_word_o[SW_IE]                    = ie_q;
    status_word_o[SW_SF]                    = sf_q;
    status_word_o[SW_ES]                    = ie_q | sf_q;
    status_word_o[SW_C0]                    = c0_q;
    status_word_o[SW_C2]                    = c2_q;
    status_word_o[SW_C3]                    = c3_q;
    status_word_o[SW_TOP_LSB +: TOP_W]      = stk_o.top;
  end

  assign busy_o       = busy_q;
  assign fault_code_o = fault_q;

endmodule

// ==== fpu_mem_if.sv ====
// Sequencer to memory port link
`timescale 1ns/1ps

interface fpu_mem_if import fpu_pkg::*; ();

  logic              start;
  logic              write;
  logic [ADDR_W-1:0] addr;
  logic [VAL_W-1:0]  wdata;
  logic              done;
  logic              err;
  logic [VAL_W-1:0]  rdata;

  modport seq (
    output start, write, addr, wdata,
    input  done, err, rdata
  );

  modport port (
    input  start, write, addr, wdata,
    output done, err, rdata
  );

endinterface

// ==== fpu_mem_port.sv ====
// Two-beat memory transfer engine
`timescale 1ns/1ps

module fpu_mem_port import fpu_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  fpu_mem_if.port           seq_i,
  output logic              mem_req_valid_o,
  input  logic              mem_req_ready_i,
  output logic              mem_req_write_o,
  output logic [ADDR_W-1:0] mem_req_addr_o,
  output logic [DATA_W-1:0] mem_req_wdata_o,
  input  logic              mem_rsp_valid_i,
  output logic              mem_rsp_ready_o,
  input  logic [DATA_W-1:0] mem_rsp_rdata_i,
  input  logic              mem_rsp_err_i
);

  logic              req_q;
  logic              rsp_q;
  logic              hi_q;
  logic              done_q;
  logic              err_q;
  logic              write_q;
  logic [ADDR_W-1:0] addr_q;
  logic [VAL_W-1:0]  data_q;
  logic              req_fire;
  logic              rsp_fire;

  assign req_fire = mem_req_valid_o & mem_req_ready_i;
  assign rsp_fire = mem_rsp_valid_i & mem_rsp_ready_o;

  assign mem_req_valid_o = req_q;
  assign mem_rsp_ready_o = rsp_q;
  assign mem_req_write_o = write_q;
  assign mem_req_addr_o  = hi_q ? addr_q + BEAT_STRIDE : addr_q;
  assign mem_req_wdata_o = hi_q ? data_q[VAL_W-1:DATA_W] : data_q[DATA_W-1:0];

  assign seq_i.done  = done_q;
  assign seq_i.err   = err_q;
  assign seq_i.rdata = data_q;

  // ------------------------------
  // Beat sequencing
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_q  <= 1'b0;
      rsp_q  <= 1'b0;
      hi_q   <= 1'b0;
      done_q <= 1'b0;
      err_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (seq_i.start) begin
        req_q <= 1'b1;
        hi_q  <= 1'b0;
        err_q <= 1'b0;
      end else if (req_fire) begin
        req_q <= 1'b0;
        rsp_q <= 1'b1;
      end else if (rsp_fire) begin
        rsp_q <= 1'b0;
        // An error ends the transfer after either beat
        if (mem_rsp_err_i || hi_q) begin
          done_q <= 1'b1;
          err_q  <= mem_rsp_err_i;
        end else begin
          hi_q  <= 1'b1;
          req_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (seq_i.start) begin
      write_q <= seq_i.write;
      addr_q  <= seq_i.addr;
      data_q  <= seq_i.wdata;
    end else if (rsp_fire && !write_q) begin
      if (hi_q)
        data_q[VAL_W-1:DATA_W] <= mem_rsp_rdata_i;
      else
        data_q[DATA_W-1:0] <= mem_rsp_rdata_i;
    end
  end

endmodule

// ==== fpu_pkg.sv ====
// FPU 8097 shared definitions
package fpu_pkg;

  // ------------------------------
  // Widths and sizes
  // ------------------------------
  localparam int DATA_W      = 32;
  localparam int VAL_W       = 64;
  localparam int ADDR_W      = 32;
  localparam int CSR_ADDR_W  = 6;
  localparam int STACK_DEPTH = 8;
  localparam int TOP_W       = 3;
  localparam int DEPTH_W     = 4;

  // ASCII "8097"
  localparam logic [DATA_W-1:0] ID_VALUE    = 32'h3830_3937;
  localparam logic [ADDR_W-1:0] BEAT_STRIDE = 32'd4;

  typedef enum logic [CSR_ADDR_W-1:0] {
    CSR_ID          = 6'h00,
    CSR_STATUS      = 6'h01,
    CSR_STATUS_WORD = 6'h02,
    CSR_MEM_ADDR    = 6'h03,
    CSR_PUSH_LO     = 6'h04,
    CSR_PUSH_HI     = 6'h05,
    CSR_POP_LO      = 6'h06,
    CSR_POP_HI      = 6'h07,
    CSR_CMD         = 6'h08
  } csr_addr_e;

  typedef enum logic [7:0] {
    CMD_NOP        = 8'h00,
    CMD_FCOM       = 8'h05,
    CMD_FCOMP      = 8'h06,
    CMD_FLD_MEM64  = 8'h10,
    CMD_FSTP_MEM64 = 8'h11
  } cmd_e;

  typedef enum logic [7:0] {
    FAULT_NONE            = 8'd0,
    FAULT_ILLEGAL_CMD     = 8'd1,
    FAULT_STACK_OVERFLOW  = 8'd2,
    FAULT_STACK_UNDERFLOW = 8'd3,
    FAULT_BUSY            = 8'd4,
    FAULT_MEM             = 8'd5
  } fault_e;

  typedef enum logic [2:0] {
    EXEC_IDLE,
    EXEC_DECODE,
    EXEC_MEM_WAIT,
    EXEC_FINISH
  } exec_state_e;

  // x87 status word bit positions
  localparam int SW_IE      = 0;
  localparam int SW_SF      = 6;
  localparam int SW_ES      = 7;
  localparam int SW_C0      = 8;
  localparam int SW_C2      = 10;
  localparam int SW_TOP_LSB = 11;
  localparam int SW_C3      = 14;

endpackage

// ==== fpu_stack.sv ====
// Eight-entry register stack
`timescale 1ns/1ps

module fpu_stack import fpu_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  fpu_stack_if.stack csr_port_i,
  fpu_stack_if.stack exec_port_i
);

  logic [VAL_W-1:0]   st_q [STACK_DEPTH];
  logic [TOP_W-1:0]   top_q;
  logic [DEPTH_W-1:0] depth_q;
  logic               exec_sel;
  logic               do_push;
  logic               do_pop;
  logic               do_wr;
  logic [VAL_W-1:0]   push_val;
  logic [VAL_W-1:0]   wr_val;

  // Sequencer requests win
  assign exec_sel = exec_port_i.push | exec_port_i.pop | exec_port_i.wr_top;
  assign do_push  = exec_sel ? exec_port_i.push      : csr_port_i.push;
  assign do_pop   = exec_sel ? exec_port_i.pop       : csr_port_i.pop;
  assign do_wr    = exec_sel ? exec_port_i.wr_top    : csr_port_i.wr_top;
  assign push_val = exec_sel ? exec_port_i.push_data : csr_port_i.push_data;
  assign wr_val   = exec_sel ? exec_port_i.wr_data   : csr_port_i.wr_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      top_q   <= '0;
      depth_q <= '0;
    end else if (do_push) begin
      top_q   <= top_q - 1'b1;
      depth_q <= depth_q + 1'b1;
    end else if (do_pop) begin
      top_q   <= top_q + 1'b1;
      depth_q <= depth_q - 1'b1;
    end
  end

  // New entry lands below the old TOP
  always_ff @(posedge clk) begin
    if (do_push)
      st_q[top_q - 1'b1] <= push_val;
    else if (do_wr)
      st_q[top_q] <= wr_val;
  end

  assign csr_port_i.top_data   = st_q[top_q];
  assign csr_port_i.next_data  = st_q[top_q + 1'b1];
  assign csr_port_i.depth      = depth_q;
  assign csr_port_i.top        = top_q;
  assign exec_port_i.top_data  = st_q[top_q];
  assign exec_port_i.next_data = st_q[top_q + 1'b1];
  assign exec_port_i.depth     = depth_q;
  assign exec_port_i.top       = top_q;

endmodule

// ==== fpu_stack_if.sv ====
// Register stack access
`timescale 1ns/1ps

interface fpu_stack_if import fpu_pkg::*; ();

  logic               push;
  logic [VAL_W-1:0]   push_data;
  logic               pop;
  logic               wr_top;
  logic [VAL_W-1:0]   wr_data;
  logic [VAL_W-1:0]   top_data;
  logic [VAL_W-1:0]   next_data;
  logic [DEPTH_W-1:0] depth;
  logic [TOP_W-1:0]   top;

  modport user (
    output push, push_data, pop, wr_top, wr_data,
    input  top_data, next_data, depth, top
  );

  modport stack (
    input  push, push_data, pop, wr_top, wr_data,
    output top_data, next_data, depth, top
  );

endinterface

// ==== src.f ====
fpu_pkg.sv
fpu_stack_if.sv
fpu_mem_if.sv
fpu_stack.sv
fpu_mem_port.sv
fpu_csr_window.sv
fpu_exec.sv
fpu_8097_top.sv
tb_fpu_8097.sv

// ==== tb_fpu_8097.sv ====
// FPU 8097 testbench
`timescale 1ns/1ps

module tb_fpu_8097 import fpu_pkg::*; ();

  typedef enum logic [1:0] {ROW_WRITE, ROW_READ, ROW_POLL} row_kind_e;

  localparam logic [ADDR_W-1:0] ERR_ADDR = 32'h0000_00C0;

  logic                  clk;
  logic                  rst_n;
  logic                  csr_req_valid_i;
  logic                  csr_req_ready_o;
  logic                  csr_req_write_i;
  logic [CSR_ADDR_W-1:0] csr_req_addr_i;
  logic [DATA_W-1:0]     csr_req_wdata_i;
  logic                  csr_rsp_valid_o;
  logic                  csr_rsp_ready_i;
  logic [DATA_W-1:0]     csr_rsp_rdata_o;
  logic                  csr_rsp_fault_o;
  logic                  mem_req_valid_o;
  logic                  mem_req_ready_i;
  logic                  mem_req_write_o;
  logic [ADDR_W-1:0]     mem_req_addr_o;
  logic [DATA_W-1:0]     mem_req_wdata_o;
  logic                  mem_rsp_valid_i;
  logic                  mem_rsp_ready_o;
  logic [DATA_W-1:0]     mem_rsp_rdata_i;
  logic                  mem_rsp_err_i;

  logic [DATA_W-1:0]     mem [64];

  string                 row_name [$];
  row_kind_e             row_kind [$];
  logic [CSR_ADDR_W-1:0] row_addr [$];
  logic [DATA_W-1:0]     row_wdata [$];
  logic [DATA_W-1:0]     row_exp [$];
  logic                  row_flt [$];
  int                    pass_count;
  int                    fail_count;
  int                    mem_faults;

  fpu_8097_top fpu_8097_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // STATUS layout: busy, fault present, depth, TOP, fault code
  function automatic logic [DATA_W-1:0] status_val(input int depth, input int top,
                                                   input fault_e code);
    logic [DATA_W-1:0] v;
    v        = '0;
    v[1]     = code != FAULT_NONE;
    v[5:2]   = depth[3:0];
    v[8:6]   = top[2:0];
    v[23:16] = code;
    return v;
  endfunction

  function automatic logic [DATA_W-1:0] sw_val(input logic ie, input logic sf, input logic c0,
                                               input logic c2, input logic c3, input int top);
    logic [DATA_W-1:0] v;
    v                         = '0;
    v[SW_IE]                  = ie;
    v[SW_SF]                  = sf;
    v[SW_ES]                  = ie | sf;
    v[SW_C0]                  = c0;
    v[SW_C2]                  = c2;
    v[SW_C3]                  = c3;
    v[SW_TOP_LSB +: TOP_W]    = top[2:0];
    return v;
  endfunction

  task automatic append_row(input string name, input row_kind_e kind,
                            input logic [CSR_ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            input logic [DATA_W-1:0] exp, input logic flt);
    row_name.push_back(name);
    row_kind.push_back(kind);
    row_addr.push_back(addr);
    row_wdata.push_back(wdata);
    row_exp.push_back(exp);
    row_flt.push_back(flt);
  endtask

  task automatic push_value(input string name, input logic [VAL_W-1:0] v);
    append_row({name, "_lo"}, ROW_WRITE, CSR_PUSH_LO, v[31:0], '0, 1'b0);
    append_row({name, "_hi"}, ROW_WRITE, CSR_PUSH_HI, v[63:32], '0, 1'b0);
  endtask

  task automatic pop_value(input string name, input logic [VAL_W-1:0] v);
    append_row({name, "_lo"}, ROW_READ, CSR_POP_LO, '0, v[31:0], 1'b0);
    append_row({name, "_hi"}, ROW_READ, CSR_POP_HI, '0, v[63:32], 1'b0);
  endtask

  task automatic run_cmd(input string name, input logic [7:0] op,
                         input logic [DATA_W-1:0] exp_status);
    append_row(name, ROW_WRITE, CSR_CMD, {24'd0, op}, '0, 1'b0);
    append_row({name, "_poll"}, ROW_POLL, CSR_STATUS, '0, exp_status, 1'b0);
  endtask

  task automatic build_table();
    int k;
    // Window decode
    append_row("id_read", ROW_READ, CSR_ID, '0, ID_VALUE, 1'b0);
    append_row("id_write", ROW_WRITE, CSR_ID, 32'h1, '0, 1'b1);
    append_row("push_lo_read", ROW_READ, CSR_PUSH_LO, '0, '0, 1'b1);
    append_row("unmapped_read", ROW_READ, 6'h2A, '0, '0, 1'b1);
    append_row("status_reset", ROW_READ, CSR_STATUS, '0, status_val(0, 0, FAULT_NONE), 1'b0);
    // ------------------------------
    // Push and pop order
    // ------------------------------
    push_value("push_a", 64'h1111_2222_3333_4444);
    push_value("push_b", 64'h5555_6666_7777_8888);
    push_value("push_c", 64'h9999_AAAA_BBBB_CCCC);
    append_row("status_three", ROW_READ, CSR_STATUS, '0, status_val(3, 5, FAULT_NONE), 1'b0);
    pop_value("pop_c", 64'h9999_AAAA_BBBB_CCCC);
    pop_value("pop_b", 64'h5555_6666_7777_8888);
    pop_value("pop_a", 64'h1111_2222_3333_4444);
    append_row("pop_empty", ROW_READ, CSR_POP_HI, '0, '0, 1'b1);
    append_row("status_underflow", ROW_READ, CSR_STATUS, '0,
               status_val(0, 0, FAULT_STACK_UNDERFLOW), 1'b0);
    append_row("sw_underflow", ROW_READ, CSR_STATUS_WORD, '0, sw_val(0, 1, 0, 0, 0, 0), 1'b0);
    // ------------------------------
    // Memory round trip
    // ------------------------------
    append_row("mem_addr_write", ROW_WRITE, CSR_MEM_ADDR, 32'h40, '0, 1'b0);
    append_row("mem_addr_read", ROW_READ, CSR_MEM_ADDR, '0, 32'h40, 1'b0);
    push_value("push_mem", 64'hC009_21FB_5444_2D18);
    run_cmd("fstp", CMD_FSTP_MEM64, status_val(0, 0, FAULT_STACK_UNDERFLOW));
    run_cmd("fld", CMD_FLD_MEM64, status_val(1, 7, FAULT_STACK_UNDERFLOW));
    pop_value("pop_loaded", 64'hC009_21FB_5444_2D18);
    append_row("mem_addr_err", ROW_WRITE, CSR_MEM_ADDR, ERR_ADDR, '0, 1'b0);
    run_cmd("fld_err", CMD_FLD_MEM64, status_val(0, 0, FAULT_MEM));
    run_cmd("illegal_cmd", 8'h7E, status_val(0, 0, FAULT_ILLEGAL_CMD));
    // ------------------------------
    // Compares, ST0 is the last push
    // ------------------------------
    push_value("push_two", 64'h4000_0000_0000_0000);
    push_value("push_one", 64'h3FF0_0000_0000_0000);
    run_cmd("fcom_less", CMD_FCOM, status_val(2, 6, FAULT_ILLEGAL_CMD));
    append_row("sw_less", ROW_READ, CSR_STATUS_WORD, '0, sw_val(0, 1, 1, 0, 0, 6), 1'b0);
    run_cmd("fcomp_less", CMD_FCOMP, status_val(1, 7, FAULT_ILLEGAL_CMD));
    append_row("sw_fcomp", ROW_READ, CSR_STATUS_WORD, '0, sw_val(0, 1, 1, 0, 0, 7), 1'b0);
    push_value("push_three", 64'h4008_0000_0000_0000);
    run_cmd("fcomp_greater", CMD_FCOMP, status_val(1, 7, FAULT_ILLEGAL_CMD));
    append_row("sw_greater", ROW_READ, CSR_STATUS_WORD, '0, sw_val(0, 1, 0, 0, 0, 7), 1'b0);
    append_row("pop_two_hi", ROW_READ, CSR_POP_HI, '0, 32'h4000_0000, 1'b0);
    push_value("push_neg_zero", 64'h8000_0000_0000_0000);
    push_value("push_pos_zero", 64'h0000_0000_0000_0000);
    run_cmd("fcomp_zeros", CMD_FCOMP, status_val(1, 7, FAULT_ILLEGAL_CMD));
    append_row("sw_equal", ROW_READ, CSR_STATUS_WORD, '0, sw_val(0, 1, 0, 0, 1, 7), 1'b0);
    push_value("push_nan", 64'h7FF8_0000_0000_0000);
    run_cmd("fcom_nan", CMD_FCOM, status_val(2, 6, FAULT_ILLEGAL_CMD));
    append_row("sw_nan", ROW_READ, CSR_STATUS_WORD, '0, sw_val(1, 1, 1, 1, 1, 6), 1'b0);
    append_row("pop_nan_hi", ROW_READ, CSR_POP_HI, '0, 32'h7FF8_0000, 1'b0);
    run_cmd("fcom_one_entry", CMD_FCOM, status_val(1, 7, FAULT_STACK_UNDERFLOW));
    // Fill up, one entry is already there
    for (k = 0; k < 7; k++) begin
      push_value($sformatf("fill_%0d", k), {32'h0BAD_0000 | k, 32'h600D_0000 | k});
    end
    append_row("overflow_lo", ROW_WRITE, CSR_PUSH_LO, 32'hDEAD_0001, '0, 1'b0);
    append_row("overflow_hi", ROW_WRITE, CSR_PUSH_HI, 32'hDEAD_0002, '0, 1'b1);
    append_row("status_full", ROW_READ, CSR_STATUS, '0,
               status_val(8, 0, FAULT_STACK_OVERFLOW), 1'b0);
    pop_value("pop_after_overflow", {32'h0BAD_0006, 32'h600D_0006});
  endtask

  // One request and its response, driven on falling edges
  task automatic csr_access(input logic is_write, input logic [CSR_ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata,
                            output logic [DATA_W-1:0] rdata, output logic flt);
    @(negedge clk);
    csr_req_valid_i = 1'b1;
    csr_req_write_i = is_write;
    csr_req_addr_i  = addr;
    csr_req_wdata_i = wdata;
    while (!csr_req_ready_o)
      @(negedge clk);
    @(negedge clk);
    csr_req_valid_i = 1'b0;
    while (!csr_rsp_valid_o)
      @(negedge clk);
    rdata           = csr_rsp_rdata_o;
    flt             = csr_rsp_fault_o;
    csr_rsp_ready_i = 1'b1;
    @(negedge clk);
    csr_rsp_ready_i = 1'b0;
  endtask

  task automatic poll_status(output logic [DATA_W-1:0] rdata, output logic flt);
    csr_access(1'b0, CSR_STATUS, '0, rdata, flt);
    while (rdata[0] == 1'b1)
      csr_access(1'b0, CSR_STATUS, '0, rdata, flt);
  endtask

  // ------------------------------
  // Memory model
  // ------------------------------
  initial begin : memory_model
    int unsigned seed_state;
    int unsigned delay;
    logic [5:0]  idx;
    logic        is_write;
    logic        is_err;
    logic [31:0] beat;
    seed_state      = $urandom(32'h42bb);
    for (int i = 0; i < 64; i++)
      mem[i] = 32'h5A00_0000 ^ (32'(i) * 32'h0004_0101);
    mem_req_ready_i = 1'b1;
    mem_rsp_valid_i = 1'b0;
    mem_rsp_rdata_i = '0;
    mem_rsp_err_i   = 1'b0;
    @(negedge clk);
    forever begin
      if (mem_req_valid_o === 1'b1) begin
        // Taken at the coming rising edge
        idx      = mem_req_addr_o[7:2];
        is_write = mem_req_write_o;
        is_err   = mem_req_addr_o == ERR_ADDR;
        beat     = mem_req_wdata_o;
        delay    = $urandom_range(3, 0);
        repeat (delay + 1) @(negedge clk);
        if (is_write && !is_err)
          mem[idx] = beat;
        mem_rsp_rdata_i = is_err ? '0 : mem[idx];
        mem_rsp_err_i   = is_err;
        mem_rsp_valid_i = 1'b1;
        // The port must already be waiting for this beat
        if (mem_rsp_ready_o !== 1'b1) begin
          $display("Memory response arrived while the port was not ready for it");
          mem_faults++;
        end
        while (mem_rsp_ready_o !== 1'b1)
          @(negedge clk);
        @(negedge clk);
        mem_rsp_valid_i = 1'b0;
        mem_rsp_err_i   = 1'b0;
      end else begin
        @(negedge clk);
      end
    end
  end

  initial begin : watchdog
    #1;
    repeat (row_name.size() * 40 + 10) @(posedge clk);
    $display("Watchdog expired before all rows finished");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : main
    logic [DATA_W-1:0] rdata;
    logic              flt;
    logic              ok;
    rst_n           = 1'b0;
    csr_req_valid_i = 1'b0;
    csr_req_write_i = 1'b0;
    csr_req_addr_i  = '0;
    csr_req_wdata_i = '0;
    csr_rsp_ready_i = 1'b0;
    pass_count      = 0;
    fail_count      = 0;
    mem_faults      = 0;
    build_table();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < row_name.size(); i++) begin
      ok = 1'b1;
      if (row_kind[i] == ROW_POLL)
        poll_status(rdata, flt);
      else
        csr_access(row_kind[i] == ROW_WRITE, row_addr[i], row_wdata[i], rdata, flt);
      if (rdata !== row_exp[i]) begin
        $display("Error %s: expected data %h, actual %h", row_name[i], row_exp[i], rdata);
        ok = 1'b0;
      end
      if (flt !== row_flt[i]) begin
        $display("Error %s: expected fault %0b, actual %0b", row_name[i], row_flt[i], flt);
        ok = 1'b0;
      end
      if (ok) begin
        pass_count++;
        $display("ok     %s", row_name[i]);
      end else begin
        fail_count++;
      end
    end
    $display("Rows: %0d  passed: %0d  failed: %0d  memory faults: %0d",
             row_name.size(), pass_count, fail_count, mem_faults);
    if (fail_count == 0 && mem_faults == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
